// ==== cipher_macros.svh ====
`ifndef CIPHER_MACROS_SVH
`define CIPHER_MACROS_SVH

// block and word geometry
`define CIPHER_BLK_W 128
`define CIPHER_WORD_W 32
`define CIPHER_BYTE_W 8

// arx core iterations
`define CIPHER_ROUNDS 8

// input block memory depth is 2**BUF_ADDR_W
`define BUF_ADDR_W 9

`endif

// ==== cipher_pkg.sv ====
`default_nettype none
`include "cipher_macros.svh"

package cipher_pkg;

        typedef logic [`CIPHER_WORD_W-1:0] cipher_cmd_t;
        typedef logic [`CIPHER_BLK_W-1:0] cipher_blk_t;
        typedef logic [`CIPHER_BLK_W-1:0] cipher_key_t;

        // job command codes
        localparam cipher_cmd_t CMD_ECB_ENC = 32'd1;
        localparam cipher_cmd_t CMD_ECB_DEC = 32'd2;
        localparam cipher_cmd_t CMD_CBC_ENC = 32'd3;
        localparam cipher_cmd_t CMD_CBC_DEC = 32'd4;

        // host writes words little-endian, the core works big-endian
        function automatic cipher_blk_t swap_word_bytes(input cipher_blk_t blk);
                localparam int BPW = `CIPHER_WORD_W / `CIPHER_BYTE_W;
                cipher_blk_t res;
                res = '0;
                for (int w = 0; w < `CIPHER_BLK_W / `CIPHER_WORD_W; w++) begin
                        for (int b = 0; b < BPW; b++) begin
                                res[w*`CIPHER_WORD_W + b*`CIPHER_BYTE_W +: `CIPHER_BYTE_W] =
                                        blk[w*`CIPHER_WORD_W + (BPW-1-b)*`CIPHER_BYTE_W +:
                                            `CIPHER_BYTE_W];
                        end
                end
                return res;
        endfunction

        function automatic logic is_cbc(input cipher_cmd_t cmd);
                return (cmd == CMD_CBC_ENC) || (cmd == CMD_CBC_DEC);
        endfunction

        function automatic logic is_decrypt(input cipher_cmd_t cmd);
                return (cmd == CMD_ECB_DEC) || (cmd == CMD_CBC_DEC);
        endfunction

endpackage

`default_nettype wire

// ==== buffer_pkg.sv ====
`default_nettype none
`include "cipher_macros.svh"

package buffer_pkg;

        // address into the input block memory
        typedef logic [`BUF_ADDR_W-1:0] buf_addr_t;

        // records per job, key and iv included
        typedef logic [`BUF_ADDR_W-1:0] blk_cnt_t;

endpackage

`default_nettype wire

// ==== block_buffer.sv ====
`default_nettype none
`include "cipher_macros.svh"

module block_buffer (
        input  wire logic                   clk,
        input  wire logic                   reset,
        input  wire logic                   we,
        input  wire buffer_pkg::buf_addr_t  wr_addr,
        input  wire cipher_pkg::cipher_blk_t wr_data,
        input  wire logic                   rd_en,
        input  wire buffer_pkg::buf_addr_t  rd_addr,
        output cipher_pkg::cipher_blk_t     rd_data
);
        import cipher_pkg::*;

        localparam int DEPTH = 2 ** `BUF_ADDR_W;

        cipher_blk_t mem [DEPTH];

        // host side
        always_ff @(posedge clk) begin
                if (we) begin
                        mem[wr_addr] <= wr_data;
                end
        end

        // registered read, data one cycle after rd_en
        always_ff @(posedge clk) begin
                if (reset) begin
                        rd_data <= '0;
                end else if (rd_en) begin
                        rd_data <= mem[rd_addr];
                end
        end

endmodule

`default_nettype wire

// ==== arx_cipher_core.sv ====
`default_nettype none
`include "cipher_macros.svh"

module arx_cipher_core (
        input  wire logic                    clk,
        input  wire logic                    reset,
        input  wire logic                    core_req,
        input  wire logic                    core_decrypt,
        input  wire cipher_pkg::cipher_key_t core_key,
        input  wire cipher_pkg::cipher_blk_t core_in,
        output logic                         core_ack,
        output cipher_pkg::cipher_blk_t      core_out
);
        import cipher_pkg::*;

        localparam int W = `CIPHER_WORD_W;
        localparam int CNT_W = $clog2(`CIPHER_ROUNDS);
        localparam logic [CNT_W-1:0] LAST = CNT_W'(`CIPHER_ROUNDS - 1);

        localparam logic [1:0] ST_IDLE = 2'd0;
        localparam logic [1:0] ST_RUN = 2'd1;
        localparam logic [1:0] ST_DONE = 2'd2;

        logic [1:0] state;
        logic [CNT_W-1:0] cnt;
        logic [CNT_W-1:0] rnd;
        logic [W-1:0] kw [4];
        logic [W-1:0] kx;
        cipher_blk_t blk;

        function automatic logic [W-1:0] rotl(input logic [W-1:0] x, input int n);
                return (x << n) | (x >> (W - n));
        endfunction

        function automatic logic [W-1:0] rotr(input logic [W-1:0] x, input int n);
                return (x >> n) | (x << (W - n));
        endfunction

        function automatic cipher_blk_t enc_round(input cipher_blk_t s, input logic [W-1:0] k);
                logic [W-1:0] w0, w1, w2, w3;
                w0 = s[4*W-1 -: W] ^ k;
                w1 = s[3*W-1 -: W] ^ k;
                w2 = s[2*W-1 -: W] ^ k;
                w3 = s[W-1:0] ^ k;
                w0 = w0 + w1;
                w3 = rotl(w3 ^ w0, 16);
                w2 = w2 + w3;
                w1 = rotl(w1 ^ w2, 12);
                return {w0, w1, w2, w3};
        endfunction

        // exact inverse of enc_round, steps undone last to first
        function automatic cipher_blk_t dec_round(input cipher_blk_t s, input logic [W-1:0] k);
                logic [W-1:0] w0, w1, w2, w3;
                w0 = s[4*W-1 -: W];
                w1 = s[3*W-1 -: W];
                w2 = s[2*W-1 -: W];
                w3 = s[W-1:0];
                w1 = rotr(w1, 12) ^ w2;
                w2 = w2 - w3;
                w3 = rotr(w3, 16) ^ w0;
                w0 = w0 - w1;
                return {w0 ^ k, w1 ^ k, w2 ^ k, w3 ^ k};
        endfunction

        // k0 is the most significant key word
        always_comb begin
                for (int i = 0; i < 4; i++) begin
                        kw[i] = core_key[(3-i)*W +: W];
                end
                rnd = core_decrypt ? LAST - cnt : cnt;
                kx = kw[rnd[1:0]] ^ W'(rnd);
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= ST_IDLE;
                        cnt <= '0;
                        core_ack <= 1'b0;
                end else begin
                        case (state)
                        ST_IDLE: begin
                                if (core_req) begin
                                        cnt <= '0;
                                        state <= ST_RUN;
                                end
                        end
                        ST_RUN: begin
                                cnt <= cnt + 1'b1;
                                if (cnt == LAST) begin
                                        core_ack <= 1'b1;
                                        state <= ST_DONE;
                                end
                        end
                        ST_DONE: begin
                                // result held until the request goes away
                                if (!core_req) begin
                                        core_ack <= 1'b0;
                                        state <= ST_IDLE;
                                end
                        end
                        default: state <= ST_IDLE;
                        endcase
                end
        end

        // datapath, one round per cycle
        always_ff @(posedge clk) begin
                if (state == ST_IDLE && core_req) begin
                        blk <= core_in;
                end else if (state == ST_RUN) begin
                        blk <= core_decrypt ? dec_round(blk, kx) : enc_round(blk, kx);
                end
        end

        assign core_out = blk;

endmodule

`default_nettype wire

// ==== cipher_controller.sv ====
`default_nettype none

module cipher_controller (
        input  wire logic                     clk,
        input  wire logic                     reset,
        input  wire logic                     job_req,
        output logic                          job_ack,
        input  wire cipher_pkg::cipher_cmd_t  job_cmd,
        input  wire buffer_pkg::blk_cnt_t     job_blk_cnt,
        input  wire logic                     job_resume,
        output logic                          rd_en,
        output buffer_pkg::buf_addr_t         rd_addr,
        input  wire cipher_pkg::cipher_blk_t  rd_data,
        output logic                          core_req,
        output logic                          core_decrypt,
        output cipher_pkg::cipher_key_t       core_key,
        output cipher_pkg::cipher_blk_t       core_in,
        input  wire logic                     core_ack,
        input  wire cipher_pkg::cipher_blk_t  core_out,
        output logic                          out_we,
        output buffer_pkg::buf_addr_t         out_addr,
        output buffer_pkg::blk_cnt_t          out_blk_no,
        output cipher_pkg::cipher_blk_t       out_blk
);
        import cipher_pkg::*;
        import buffer_pkg::*;

        localparam logic [2:0] ST_IDLE = 3'd0;
        localparam logic [2:0] ST_FETCH = 3'd1;
        localparam logic [2:0] ST_KEY = 3'd2;
        localparam logic [2:0] ST_IV = 3'd3;
        localparam logic [2:0] ST_PROC = 3'd4;
        localparam logic [2:0] ST_FINISH = 3'd5;

        logic [2:0] state;
        cipher_cmd_t cmd;
        logic resume;
        blk_cnt_t cnt;
        blk_cnt_t pay_cnt;
        buf_addr_t nxt_addr;
        logic rd_vld;
        logic pf_vld;
        cipher_blk_t pf_blk;
        cipher_blk_t iv;
        cipher_blk_t res;

        // payload records left after the key and iv
        always_comb begin
                if (resume) begin
                        pay_cnt = cnt;
                end else if (is_cbc(cmd)) begin
                        pay_cnt = cnt - 2'd2;
                end else begin
                        pay_cnt = cnt - 1'b1;
                end
        end

        // cbc decrypt unchains on the way out
        assign res = (is_cbc(cmd) && is_decrypt(cmd)) ? core_out ^ iv : core_out;
        assign core_decrypt = is_decrypt(cmd);

        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= ST_IDLE;
                        cmd <= '0;
                        resume <= 1'b0;
                        cnt <= '0;
                        nxt_addr <= '0;
                        rd_en <= 1'b0;
                        rd_vld <= 1'b0;
                        pf_vld <= 1'b0;
                        core_req <= 1'b0;
                        core_key <= '0;
                        iv <= '0;
                        job_ack <= 1'b0;
                        out_we <= 1'b0;
                        out_blk_no <= '0;
                end else begin
                        rd_en <= 1'b0;
                        rd_vld <= rd_en;
                        out_we <= 1'b0;

                        case (state)
                        ST_IDLE: begin
                                if (job_req && !job_ack) begin
                                        cmd <= job_cmd;
                                        resume <= job_resume;
                                        cnt <= job_blk_cnt;
                                        nxt_addr <= '0;
                                        pf_vld <= 1'b0;
                                        out_blk_no <= '0;
                                        state <= ST_FETCH;
                                end
                        end
                        ST_FETCH: begin
                                // resumed jobs keep key and iv, all records are payload
                                if (resume) begin
                                        state <= ST_PROC;
                                end else begin
                                        rd_en <= 1'b1;
                                        rd_addr <= nxt_addr;
                                        nxt_addr <= nxt_addr + 1'b1;
                                        state <= ST_KEY;
                                end
                        end
                        ST_KEY: begin
                                if (rd_vld) begin
                                        core_key <= swap_word_bytes(rd_data);
                                        if (is_cbc(cmd)) begin
                                                rd_en <= 1'b1;
                                                rd_addr <= nxt_addr;
                                                nxt_addr <= nxt_addr + 1'b1;
                                                state <= ST_IV;
                                        end else begin
                                                state <= ST_PROC;
                                        end
                                end
                        end
                        ST_IV: begin
                                if (rd_vld) begin
                                        iv <= swap_word_bytes(rd_data);
                                        state <= ST_PROC;
                                end
                        end
                        ST_PROC: begin
                                // prefetch the next block while the core is busy
                                if (!pf_vld && !rd_en && !rd_vld && nxt_addr < cnt) begin
                                        rd_en <= 1'b1;
                                        rd_addr <= nxt_addr;
                                        nxt_addr <= nxt_addr + 1'b1;
                                end
                                if (rd_vld) begin
                                        pf_blk <= swap_word_bytes(rd_data);
                                        pf_vld <= 1'b1;
                                end

                                // launch once the previous handshake has fully closed
                                if (pf_vld && !core_req && !core_ack) begin
                                        core_in <= (is_cbc(cmd) && !is_decrypt(cmd)) ?
                                                pf_blk ^ iv : pf_blk;
                                        core_req <= 1'b1;
                                        pf_vld <= 1'b0;
                                end

                                if (core_req && core_ack) begin
                                        core_req <= 1'b0;
                                        out_we <= 1'b1;
                                        out_addr <= out_blk_no;
                                        out_blk_no <= out_blk_no + 1'b1;
                                        out_blk <= swap_word_bytes(res);
                                        if (is_cbc(cmd)) begin
                                                iv <= is_decrypt(cmd) ? core_in : core_out;
                                        end
                                end

                                if (out_blk_no == pay_cnt && !core_req && !core_ack) begin
                                        state <= ST_FINISH;
                                end
                        end
                        ST_FINISH: begin
                                job_ack <= 1'b1;
                                if (job_ack && !job_req) begin
                                        job_ack <= 1'b0;
                                        state <= ST_IDLE;
                                end
                        end
                        default: state <= ST_IDLE;
                        endcase
                end
        end

endmodule

`default_nettype wire

// ==== cipher_subsystem_top.sv ====
`default_nettype none

module cipher_subsystem_top (
        input  wire logic                     clk,
        input  wire logic                     reset,
        input  wire logic                     load_we,
        input  wire buffer_pkg::buf_addr_t    load_addr,
        input  wire cipher_pkg::cipher_blk_t  load_data,
        input  wire logic                     job_req,
        output logic                          job_ack,
        input  wire cipher_pkg::cipher_cmd_t  job_cmd,
        input  wire buffer_pkg::blk_cnt_t     job_blk_cnt,
        input  wire logic                     job_resume,
        output logic                          out_we,
        output buffer_pkg::buf_addr_t         out_addr,
        output buffer_pkg::blk_cnt_t          out_blk_no,
        output cipher_pkg::cipher_blk_t       out_blk
);
        import cipher_pkg::*;
        import buffer_pkg::*;

        // buffer read side
        logic rd_en;
        buf_addr_t rd_addr;
        cipher_blk_t rd_data;

        // core handshake
        logic core_req;
        logic core_decrypt;
        cipher_key_t core_key;
        cipher_blk_t core_in;
        logic core_ack;
        cipher_blk_t core_out;

        block_buffer u_buffer (
                .clk     (clk),
                .reset   (reset),
                .we      (load_we),
                .wr_addr (load_addr),
                .wr_data (load_data),
                .rd_en   (rd_en),
                .rd_addr (rd_addr),
                .rd_data (rd_data)
        );

        cipher_controller u_ctrl (
                .clk          (clk),
                .reset        (reset),
                .job_req      (job_req),
                .job_ack      (job_ack),
                .job_cmd      (job_cmd),
                .job_blk_cnt  (job_blk_cnt),
                .job_resume   (job_resume),
                .rd_en        (rd_en),
                .rd_addr      (rd_addr),
                .rd_data      (rd_data),
                .core_req     (core_req),
                .core_decrypt (core_decrypt),
                .core_key     (core_key),
                .core_in      (core_in),
                .core_ack     (core_ack),
                .core_out     (core_out),
                .out_we       (out_we),
                .out_addr     (out_addr),
                .out_blk_no   (out_blk_no),
                .out_blk      (out_blk)
        );

        arx_cipher_core u_core (
                .clk          (clk),
                .reset        (reset),
                .core_req     (core_req),
                .core_decrypt (core_decrypt),
                .core_key     (core_key),
                .core_in      (core_in),
                .core_ack     (core_ack),
                .core_out     (core_out)
        );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
        output logic clk
);
        // free running, 4 time units per period
        initial begin
                clk = 1'b0;
                forever begin
                        #2 clk = ~clk;
                end
        end

endmodule

`default_nettype wire

// ==== cipher_subsystem_tb.sv ====
`default_nettype none

module cipher_subsystem_tb;
        import cipher_pkg::*;
        import buffer_pkg::*;

        localparam int MAX_WORDS = 128;

        logic clk;
        logic reset;
        logic load_we;
        buf_addr_t load_addr;
        cipher_blk_t load_data;
        logic job_req;
        logic job_ack;
        cipher_cmd_t job_cmd;
        blk_cnt_t job_blk_cnt;
        logic job_resume;
        logic out_we;
        buf_addr_t out_addr;
        blk_cnt_t out_blk_no;
        cipher_blk_t out_blk;

        // header, input records and expected blocks of every job
        cipher_blk_t test_words [MAX_WORDS];
        cipher_blk_t exp_q [$];
        cipher_blk_t exp_blk;
        int out_seen = 0;
        int budget_cycles = 0;

        tb_clock_gen u_clk (
                .clk (clk)
        );

        cipher_subsystem_top u_dut (
                .clk         (clk),
                .reset       (reset),
                .load_we     (load_we),
                .load_addr   (load_addr),
                .load_data   (load_data),
                .job_req     (job_req),
                .job_ack     (job_ack),
                .job_cmd     (job_cmd),
                .job_blk_cnt (job_blk_cnt),
                .job_resume  (job_resume),
                .out_we      (out_we),
                .out_addr    (out_addr),
                .out_blk_no  (out_blk_no),
                .out_blk     (out_blk)
        );

        task automatic abort_run(input string why);
                $display("%s", why);
                $display("Testbench failed");
                $fatal(1, "run stopped");
        endtask

        task automatic check_value(input string name, input cipher_blk_t actual,
                                   input cipher_blk_t expected);
                if (actual !== expected) begin
                        $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
                        $display("Testbench failed");
                        $fatal(1, "check failed");
                end
        endtask

        // header word: command, resume flag, record count, unused
        function automatic int record_count(input cipher_blk_t hdr);
                return int'(hdr[63:32]);
        endfunction

        function automatic int payload_count(input cipher_blk_t hdr);
                int cnt;
                cnt = record_count(hdr);
                if (hdr[64]) begin
                        return cnt;
                end else if (hdr[127:96] == CMD_CBC_ENC || hdr[127:96] == CMD_CBC_DEC) begin
                        return cnt - 2;
                end else begin
                        return cnt - 1;
                end
        endfunction

        function automatic int total_records();
                int idx;
                int total;
                idx = 0;
                total = 0;
                while (idx < MAX_WORDS && test_words[idx][127:96] != '0) begin
                        total += record_count(test_words[idx]);
                        idx += 1 + record_count(test_words[idx]) + payload_count(test_words[idx]);
                end
                return total;
        endfunction

        task automatic run_job(input int base);
                cipher_blk_t hdr;
                int cnt;
                int pay;
                hdr = test_words[base];
                cnt = record_count(hdr);
                pay = payload_count(hdr);

                // fill the buffer from address 0
                for (int i = 0; i < cnt; i++) begin
                        @(negedge clk);
                        load_we = 1'b1;
                        load_addr = buf_addr_t'(i);
                        load_data = test_words[base + 1 + i];
                end
                @(negedge clk);
                load_we = 1'b0;

                for (int i = 0; i < pay; i++) begin
                        exp_q.push_back(test_words[base + 1 + cnt + i]);
                end
                out_seen = 0;

                job_cmd = hdr[127:96];
                job_blk_cnt = blk_cnt_t'(cnt);
                job_resume = hdr[64];
                job_req = 1'b1;
                while (!job_ack) begin
                        @(negedge clk);
                end

                // every write has landed before the ack
                check_value("out write count", cipher_blk_t'(out_seen), cipher_blk_t'(pay));

                // ack holds while the request is up
                repeat (2) begin
                        @(negedge clk);
                        check_value("job_ack", cipher_blk_t'(job_ack), cipher_blk_t'(1));
                end
                job_req = 1'b0;
                @(negedge clk);
                check_value("job_ack", cipher_blk_t'(job_ack), cipher_blk_t'(0));
        endtask

        // output port monitor, one expected block per write pulse
        always @(negedge clk) begin
                if (!reset && out_we) begin
                        if (exp_q.size() == 0) begin
                                abort_run("output write seen while no block was expected");
                        end else begin
                                exp_blk = exp_q.pop_front();
                                check_value("out_blk", out_blk, exp_blk);
                                check_value("out_addr", cipher_blk_t'(out_addr),
                                            cipher_blk_t'(out_seen));
                                check_value("out_blk_no", cipher_blk_t'(out_blk_no),
                                            cipher_blk_t'(out_seen + 1));
                                out_seen++;
                        end
                end
        end

        // watchdog sized from the records in the tests file
        initial begin
                wait (budget_cycles > 0);
                repeat (budget_cycles) @(posedge clk);
                $display("timeout after %0d cycles, a job did not complete", budget_cycles);
                $display("Testbench failed");
                $fatal(1, "watchdog expired");
        end

        initial begin
                int idx;
                int jobs;
                reset = 1'b1;
                load_we = 1'b0;
                load_addr = '0;
                load_data = '0;
                job_req = 1'b0;
                job_cmd = '0;
                job_blk_cnt = '0;
                job_resume = 1'b0;
                idx = 0;
                jobs = 0;

                for (int i = 0; i < MAX_WORDS; i++) begin
                        test_words[i] = '0;
                end
                $readmemh("cipher_subsystem_tests.txt", test_words);
                budget_cycles = total_records() * 20 + 200;

                repeat (5) @(negedge clk);
                reset = 1'b0;
                check_value("job_ack", cipher_blk_t'(job_ack), cipher_blk_t'(0));
                check_value("out_we", cipher_blk_t'(out_we), cipher_blk_t'(0));

                while (idx < MAX_WORDS && test_words[idx][127:96] != '0) begin
                        run_job(idx);
                        jobs++;
                        idx += 1 + record_count(test_words[idx]) + payload_count(test_words[idx]);
                end

                if (jobs == 0) begin
                        abort_run("no job records found in the tests file");
                end else begin
                        $display("Testbench passed");
                        $finish;
                end
        end

endmodule

`default_nettype wire

// ==== cipher_subsystem_tests.txt ====
// header: command _ resume _ record count _ 0, then the input records in host
// byte order, then one expected output block per payload record
// ecb encrypt, zero key and 3 zero blocks
00000001_00000000_00000004_00000000
00000000_00000000_00000000_00000000
00000000_00000000_00000000_00000000
00000000_00000000_00000000_00000000
00000000_00000000_00000000_00000000
a0c72366_3a9a12b4_6eef71a7_5bdf498e
a0c72366_3a9a12b4_6eef71a7_5bdf498e
a0c72366_3a9a12b4_6eef71a7_5bdf498e
// ecb decrypt of those ciphertexts
00000002_00000000_00000004_00000000
00000000_00000000_00000000_00000000
a0c72366_3a9a12b4_6eef71a7_5bdf498e
a0c72366_3a9a12b4_6eef71a7_5bdf498e
a0c72366_3a9a12b4_6eef71a7_5bdf498e
00000000_00000000_00000000_00000000
00000000_00000000_00000000_00000000
00000000_00000000_00000000_00000000
// cbc encrypt, key, iv and 4 blocks
00000003_00000000_00000006_00000000
00000000_00000000_00000000_00000000
00112233_44556677_8899aabb_ccddeeff
00112233_44556677_8899aabb_ccddeeff
a0c72366_3a9a12b4_6eef71a7_5bdf498e
a0c72366_3a9a12b4_6eef71a7_5bdf498e
a0c72366_3a9a12b4_6eef71a7_5bdf498e
a0c72366_3a9a12b4_6eef71a7_5bdf498e
a0c72366_3a9a12b4_6eef71a7_5bdf498e
a0c72366_3a9a12b4_6eef71a7_5bdf498e
a0c72366_3a9a12b4_6eef71a7_5bdf498e
// cbc decrypt of the chained ciphertexts
00000004_00000000_00000006_00000000
00000000_00000000_00000000_00000000
00112233_44556677_8899aabb_ccddeeff
a0c72366_3a9a12b4_6eef71a7_5bdf498e
a0c72366_3a9a12b4_6eef71a7_5bdf498e
a0c72366_3a9a12b4_6eef71a7_5bdf498e
a0c72366_3a9a12b4_6eef71a7_5bdf498e
00112233_44556677_8899aabb_ccddeeff
a0c72366_3a9a12b4_6eef71a7_5bdf498e
a0c72366_3a9a12b4_6eef71a7_5bdf498e
a0c72366_3a9a12b4_6eef71a7_5bdf498e
// resumed cbc encrypt, chain continues from the last ciphertext
00000003_00000001_00000002_00000000
a0c72366_3a9a12b4_6eef71a7_5bdf498e
a0c72366_3a9a12b4_6eef71a7_5bdf498e
a0c72366_3a9a12b4_6eef71a7_5bdf498e
a0c72366_3a9a12b4_6eef71a7_5bdf498e
// end of jobs
00000000_00000000_00000000_00000000

// ==== cipher_subsystem.f ====
+incdir+.
cipher_pkg.sv
buffer_pkg.sv
block_buffer.sv
arx_cipher_core.sv
cipher_controller.sv
cipher_subsystem_top.sv
tb_clock_gen.sv
cipher_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cipher subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cipher_subsystem_tb \
        -f cipher_subsystem.f -o cipher_sim
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

sim_out=$(./obj_dir/cipher_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
        echo "simulation exited with status $sim_status"
        exit 1
fi

if echo "$sim_out" | grep -qx "Testbench passed"; then
        exit 0
fi
echo "pass message not found in simulation output"
exit 1
